//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_i2s_audio_bridge
FLIST     = files.f
LOG       = sim.log
RUN_ARGS  = +verilator+error+limit+1000
FAIL_MSG  = Done: errors found
PASS_MSG  = Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	-./obj_dir/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir $(LOG)

//--- files.f
rtl/i2s_pkg.sv
rtl/i2s_edge_sync.sv
rtl/i2s_playback_shifter.sv
rtl/i2s_capture_shifter.sv
rtl/i2s_audio_bridge.sv
test/i2s_audio_bridge_assert.sv
test/tb_i2s_audio_bridge.sv

//--- rtl/i2s_audio_bridge.sv
// slave mode i2s bridge top with edge synchroniser, playback and capture shifters
`timescale 1ns/1ps

module i2s_audio_bridge (
        input  logic            clock_bridge_0_out_clk_clk,
        input  logic            hps_0_h2f_reset_reset_n,
        // codec side
        input  logic            aud_bclk,
        input  logic            aud_lrclk,
        input  logic            aud_adcdat,
        output logic            aud_dacdat,
        // playback fifo
        input  logic            playback_dma_enable,
        input  logic            playback_fifo_empty,
        input  i2s_pkg::frame_t playback_fifo_data,
        output logic            playback_fifo_read,
        // capture fifo
        input  logic            capture_dma_enable,
        input  logic            capture_fifo_full,
        output logic            capture_fifo_write,
        output i2s_pkg::frame_t capture_fifo_data
);

        // strobes and aligned levels shared by both directions
        logic bclk_rise;
        logic bclk_fall;
        logic lrclk_sync;
        logic adcdat_sync;

        i2s_edge_sync u_edge_sync (
                .clock_bridge_0_out_clk_clk (clock_bridge_0_out_clk_clk),
                .hps_0_h2f_reset_reset_n    (hps_0_h2f_reset_reset_n),
                .aud_bclk                   (aud_bclk),
                .aud_lrclk                  (aud_lrclk),
                .aud_adcdat                 (aud_adcdat),
                .bclk_rise                  (bclk_rise),
                .bclk_fall                  (bclk_fall),
                .lrclk_sync                 (lrclk_sync),
                .adcdat_sync                (adcdat_sync)
        );

        i2s_playback_shifter u_playback (
                .clock_bridge_0_out_clk_clk (clock_bridge_0_out_clk_clk),
                .hps_0_h2f_reset_reset_n    (hps_0_h2f_reset_reset_n),
                .bclk_fall                  (bclk_fall),
                .lrclk_sync                 (lrclk_sync),
                .dma_enable                 (playback_dma_enable),
                .fifo_empty                 (playback_fifo_empty),
                .fifo_data                  (playback_fifo_data),
                .fifo_read                  (playback_fifo_read),
                .dacdat                     (aud_dacdat)
        );

        i2s_capture_shifter u_capture (
                .clock_bridge_0_out_clk_clk (clock_bridge_0_out_clk_clk),
                .hps_0_h2f_reset_reset_n    (hps_0_h2f_reset_reset_n),
                .bclk_rise                  (bclk_rise),
                .bclk_fall                  (bclk_fall),
                .lrclk_sync                 (lrclk_sync),
                .adcdat_sync                (adcdat_sync),
                .dma_enable                 (capture_dma_enable),
                .fifo_full                  (capture_fifo_full),
                .fifo_write                 (capture_fifo_write),
                .fifo_data                  (capture_fifo_data)
        );

endmodule

//--- rtl/i2s_capture_shifter.sv
// adc data deserialiser, frame assembly and capture fifo write gating
`timescale 1ns/1ps

module i2s_capture_shifter (
        input  logic            clock_bridge_0_out_clk_clk,
        input  logic            hps_0_h2f_reset_reset_n,
        input  logic            bclk_rise,      // sample point for adc data
        input  logic            bclk_fall,      // word clock changes here
        input  logic            lrclk_sync,
        input  logic            adcdat_sync,
        input  logic            dma_enable,
        input  logic            fifo_full,
        output logic            fifo_write,     // stores fifo_data this cycle
        output i2s_pkg::frame_t fifo_data
);

        i2s_pkg::cap_state_t state;
        i2s_pkg::sample_t    left_q;            // older 32 bits of the window
        i2s_pkg::sample_t    right_q;           // newest 32 bits
        i2s_pkg::sample_t    left_nx;
        i2s_pkg::sample_t    right_nx;
        logic                lrclk_prev;
        logic                boundary;          // word clock fell, last bit still due
        logic                frame_done;

        // one 64 bit window split in two, right feeds left
        assign right_nx = {right_q[i2s_pkg::sample_w-2:0], adcdat_sync};
        assign left_nx  = {left_q[i2s_pkg::sample_w-2:0], right_q[i2s_pkg::sample_w-1]};

        // right lsb arrives on the first rise after the boundary
        assign frame_done = bclk_rise & boundary;

        // dropped when gated, collecting carries on regardless
        assign fifo_write = (state == i2s_pkg::cap_commit) & dma_enable & ~fifo_full;

        // ==================================================
        // word clock boundary tracking
        // ==================================================

        always_ff @(posedge clock_bridge_0_out_clk_clk or negedge hps_0_h2f_reset_reset_n) begin
                if (!hps_0_h2f_reset_reset_n) begin
                        lrclk_prev <= 1'b0;
                        boundary   <= 1'b0;
                end else begin
                        if (bclk_fall) begin
                                lrclk_prev <= lrclk_sync;
                                if (lrclk_prev & ~lrclk_sync)
                                        boundary <= 1'b1;       // high to low
                        end
                        if (bclk_rise)
                                boundary <= 1'b0;               // consumed by this rise
                end
        end

        // ==================================================
        // deserialiser and frame register
        // ==================================================

        always_ff @(posedge clock_bridge_0_out_clk_clk) begin
                if (bclk_rise) begin
                        left_q  <= left_nx;
                        right_q <= right_nx;
                        if (boundary)
                                fifo_data <= {right_nx, left_nx};  // left in low half
                end
        end

        // ==================================================
        // frame fsm
        // ==================================================

        always_ff @(posedge clock_bridge_0_out_clk_clk or negedge hps_0_h2f_reset_reset_n) begin
                if (!hps_0_h2f_reset_reset_n) begin
                        state <= i2s_pkg::cap_hunt;
                end else begin
                        case (state)
                        i2s_pkg::cap_hunt: begin
                                if (frame_done)
                                        state <= i2s_pkg::cap_collect;  // partial frame dropped
                        end
                        i2s_pkg::cap_collect: begin
                                if (frame_done)
                                        state <= i2s_pkg::cap_commit;
                        end
                        i2s_pkg::cap_commit: begin
                                state <= i2s_pkg::cap_collect;  // single write cycle
                        end
                        default: begin
                                state <= i2s_pkg::cap_hunt;
                        end
                        endcase
                end
        end

endmodule

//--- rtl/i2s_edge_sync.sv
// codec pin synchronisers and bit clock rise and fall strobe generation
`timescale 1ns/1ps

module i2s_edge_sync (
        input  logic clock_bridge_0_out_clk_clk,
        input  logic hps_0_h2f_reset_reset_n,
        input  logic aud_bclk,          // codec bit clock, async
        input  logic aud_lrclk,         // codec word clock, async
        input  logic aud_adcdat,        // codec adc data, async
        output logic bclk_rise,         // one cycle pulse
        output logic bclk_fall,         // one cycle pulse
        output logic lrclk_sync,
        output logic adcdat_sync
);

        // three flop chains, bit 0 takes the pin
        logic [i2s_pkg::sync_stages-1:0] bclk_meta;
        logic [i2s_pkg::sync_stages-1:0] lrclk_meta;
        logic [i2s_pkg::sync_stages-1:0] adcdat_meta;

        logic bclk_last;        // previous value of last bclk stage
        logic bclk_up;
        logic bclk_down;

        // edge detect on the settled end of the chain
        assign bclk_up   =  bclk_meta[i2s_pkg::sync_stages-1] & ~bclk_last;
        assign bclk_down = ~bclk_meta[i2s_pkg::sync_stages-1] &  bclk_last;

        // ==================================================
        // synchroniser chains
        // ==================================================

        always_ff @(posedge clock_bridge_0_out_clk_clk or negedge hps_0_h2f_reset_reset_n) begin
                if (!hps_0_h2f_reset_reset_n) begin
                        bclk_meta   <= '0;
                        lrclk_meta  <= '0;
                        adcdat_meta <= '0;
                        bclk_last   <= 1'b0;
                end else begin
                        bclk_meta   <= {bclk_meta[i2s_pkg::sync_stages-2:0], aud_bclk};
                        lrclk_meta  <= {lrclk_meta[i2s_pkg::sync_stages-2:0], aud_lrclk};
                        adcdat_meta <= {adcdat_meta[i2s_pkg::sync_stages-2:0], aud_adcdat};
                        bclk_last   <= bclk_meta[i2s_pkg::sync_stages-1];
                end
        end

        // ==================================================
        // aligned outputs
        // ==================================================

        // word clock and data taken from the same stage as the strobes
        // so both are valid in the strobe cycle
        always_ff @(posedge clock_bridge_0_out_clk_clk or negedge hps_0_h2f_reset_reset_n) begin
                if (!hps_0_h2f_reset_reset_n) begin
                        bclk_rise   <= 1'b0;
                        bclk_fall   <= 1'b0;
                        lrclk_sync  <= 1'b0;
                        adcdat_sync <= 1'b0;
                end else begin
                        bclk_rise   <= bclk_up;         // pin edge plus 4 cycles
                        bclk_fall   <= bclk_down;
                        lrclk_sync  <= lrclk_meta[i2s_pkg::sync_stages-1];
                        adcdat_sync <= adcdat_meta[i2s_pkg::sync_stages-1];
                end
        end

endmodule

//--- rtl/i2s_pkg.sv
// audio widths, sample and frame types, synchroniser depth and fsm state encodings
package i2s_pkg;

        // ==================================================
        // widths
        // ==================================================

        localparam int sample_w    = 32;             // one channel sample
        localparam int frame_w     = 2 * sample_w;   // left in low half, right in high half
        localparam int bit_cnt_w   = 6;              // enough for 64 bit slots

        // codec pins cross into the system clock through this many flops
        localparam int sync_stages = 3;

        // ==================================================
        // data types
        // ==================================================

        typedef logic [sample_w-1:0]  sample_t;      // one channel word
        typedef logic [frame_w-1:0]   frame_t;       // one fifo word
        typedef logic [bit_cnt_w-1:0] bit_cnt_t;     // bit position inside a frame

        // ==================================================
        // state machines
        // ==================================================

        // playback side
        typedef enum logic [1:0] {
                play_idle,      // nothing loaded, dac line held low
                play_armed,     // frame latched, msb due on next falling edge
                play_shift      // bits going out
        } play_state_t;

        // capture side
        typedef enum logic [1:0] {
                cap_hunt,       // frame in flight at reset, thrown away
                cap_collect,    // gathering a full frame
                cap_commit      // write cycle toward the capture fifo
        } cap_state_t;

endpackage

//--- rtl/i2s_playback_shifter.sv
// playback frame loader and msb first dac data serialiser with i2s one bit delay
`timescale 1ns/1ps

module i2s_playback_shifter (
        input  logic            clock_bridge_0_out_clk_clk,
        input  logic            hps_0_h2f_reset_reset_n,
        input  logic            bclk_fall,      // falling bit clock strobe
        input  logic            lrclk_sync,
        input  logic            dma_enable,
        input  logic            fifo_empty,
        input  i2s_pkg::frame_t fifo_data,      // show-ahead word
        output logic            fifo_read,      // consumes fifo_data this cycle
        output logic            dacdat
);

        i2s_pkg::play_state_t state;
        i2s_pkg::bit_cnt_t    bit_cnt;          // bits already sent of this frame
        i2s_pkg::frame_t      shift_q;          // left word on top, right below
        logic                 lrclk_prev;       // word clock at previous falling strobe
        logic                 frame_start;

        // left channel begins when word clock drops
        assign frame_start = bclk_fall & lrclk_prev & ~lrclk_sync;

        // take a word only when dma is on and one is there
        assign fifo_read = frame_start & dma_enable & ~fifo_empty;

        // ==================================================
        // word clock history
        // ==================================================

        always_ff @(posedge clock_bridge_0_out_clk_clk or negedge hps_0_h2f_reset_reset_n) begin
                if (!hps_0_h2f_reset_reset_n)
                        lrclk_prev <= 1'b0;
                else if (bclk_fall)
                        lrclk_prev <= lrclk_sync;
        end

        // ==================================================
        // frame shift register
        // ==================================================

        // fifo word holds left in low half, swap so left leaves first
        always_ff @(posedge clock_bridge_0_out_clk_clk) begin
                if (frame_start) begin
                        if (fifo_read)
                                shift_q <= {fifo_data[i2s_pkg::sample_w-1:0],
                                            fifo_data[i2s_pkg::frame_w-1:i2s_pkg::sample_w]};
                        else
                                shift_q <= '0;          // underrun or dma off plays silence
                end else if (bclk_fall) begin
                        shift_q <= {shift_q[i2s_pkg::frame_w-2:0], 1'b0};
                end
        end

        // ==================================================
        // control fsm and dac output
        // ==================================================

        // dac line moves one cycle after each falling strobe
        always_ff @(posedge clock_bridge_0_out_clk_clk or negedge hps_0_h2f_reset_reset_n) begin
                if (!hps_0_h2f_reset_reset_n) begin
                        state   <= i2s_pkg::play_idle;
                        bit_cnt <= '0;
                        dacdat  <= 1'b0;
                end else if (bclk_fall) begin
                        case (state)
                        i2s_pkg::play_idle: begin
                                dacdat <= 1'b0;
                        end
                        i2s_pkg::play_armed: begin
                                dacdat  <= shift_q[i2s_pkg::frame_w-1];  // left msb
                                bit_cnt <= i2s_pkg::bit_cnt_t'(1);
                                state   <= i2s_pkg::play_shift;
                        end
                        i2s_pkg::play_shift: begin
                                dacdat  <= shift_q[i2s_pkg::frame_w-1];
                                bit_cnt <= bit_cnt + i2s_pkg::bit_cnt_t'(1);
                                // 64th bit with no new frame start means lost sync
                                if (bit_cnt == '1)
                                        state <= i2s_pkg::play_idle;
                        end
                        default: begin
                                state <= i2s_pkg::play_idle;
                        end
                        endcase
                        // right lsb and next load share this strobe
                        if (frame_start) begin
                                state   <= i2s_pkg::play_armed;
                                bit_cnt <= '0;
                        end
                end
        end

endmodule

//--- test/i2s_audio_bridge_assert.sv
// concurrent properties on the playback read and capture write strobes, bound to the bridge
`timescale 1ns/1ps

module i2s_audio_bridge_assert (
        input logic clock_bridge_0_out_clk_clk,
        input logic hps_0_h2f_reset_reset_n,
        input logic playback_fifo_read,
        input logic playback_fifo_empty,
        input logic capture_fifo_write,
        input logic capture_fifo_full
);

        int fail_count = 0;     // failed properties so far

        // one word per frame start
        read_single: assert property (@(posedge clock_bridge_0_out_clk_clk)
                disable iff (!hps_0_h2f_reset_reset_n)
                playback_fifo_read |=> !playback_fifo_read)
                else begin
                        $error("playback fifo read high for two cycles");
                        fail_count = fail_count + 1;
                end

        read_not_empty: assert property (@(posedge clock_bridge_0_out_clk_clk)
                disable iff (!hps_0_h2f_reset_reset_n)
                !(playback_fifo_read && playback_fifo_empty))
                else begin
                        $error("playback fifo read while empty");
                        fail_count = fail_count + 1;
                end

        write_not_full: assert property (@(posedge clock_bridge_0_out_clk_clk)
                disable iff (!hps_0_h2f_reset_reset_n)
                !(capture_fifo_write && capture_fifo_full))
                else begin
                        $error("capture fifo write while full");
                        fail_count = fail_count + 1;
                end

        // commit state lasts a single cycle
        write_single: assert property (@(posedge clock_bridge_0_out_clk_clk)
                disable iff (!hps_0_h2f_reset_reset_n)
                capture_fifo_write |=> !capture_fifo_write)
                else begin
                        $error("capture fifo write high for two cycles");
                        fail_count = fail_count + 1;
                end

endmodule

bind i2s_audio_bridge i2s_audio_bridge_assert u_assert (
        .clock_bridge_0_out_clk_clk (clock_bridge_0_out_clk_clk),
        .hps_0_h2f_reset_reset_n    (hps_0_h2f_reset_reset_n),
        .playback_fifo_read         (playback_fifo_read),
        .playback_fifo_empty        (playback_fifo_empty),
        .capture_fifo_write         (capture_fifo_write),
        .capture_fifo_full          (capture_fifo_full)
);

//--- test/tb_i2s_audio_bridge.sv
// testbench for the i2s audio bridge with lfsr codec model, fifo models, checks and watchdog
`timescale 1ns/1ps

module tb_i2s_audio_bridge;

        localparam int          clk_period  = 20;
        localparam int          bclk_half   = 8;        // system cycles per bit clock phase
        localparam int          n_frames    = 24;       // sum over all tests below
        localparam logic [31:0] seed        = 32'h21f;
        localparam int          watchdog_ns = n_frames * i2s_pkg::frame_w * bclk_half * 2
                                              * clk_period * 2;

        logic            clock_bridge_0_out_clk_clk;
        logic            hps_0_h2f_reset_reset_n;
        logic            aud_bclk;
        logic            aud_lrclk;
        logic            aud_adcdat;
        logic            aud_dacdat;
        logic            playback_dma_enable;
        logic            playback_fifo_empty;
        i2s_pkg::frame_t playback_fifo_data;
        logic            playback_fifo_read;
        logic            capture_dma_enable;
        logic            capture_fifo_full;
        logic            capture_fifo_write;
        i2s_pkg::frame_t capture_fifo_data;

        i2s_pkg::frame_t play_q[$];     // show-ahead playback fifo with its front word presented
        i2s_pkg::frame_t play_expect;   // frame due on the dac line this frame period
        i2s_pkg::frame_t cap_last;      // newest word written by the dut
        logic [31:0]     lfsr;
        logic            pop_pending;   // read pulse seen one cycle ago
        logic            quiet;         // dut outputs must stay low
        int              reads_seen;
        int              writes_seen;
        int              errors;
        int              checks;
        int              frames_run;
        int              test_errors;
        int              test_frames;

        i2s_audio_bridge uut (
                .clock_bridge_0_out_clk_clk (clock_bridge_0_out_clk_clk),
                .hps_0_h2f_reset_reset_n    (hps_0_h2f_reset_reset_n),
                .aud_bclk                   (aud_bclk),
                .aud_lrclk                  (aud_lrclk),
                .aud_adcdat                 (aud_adcdat),
                .aud_dacdat                 (aud_dacdat),
                .playback_dma_enable        (playback_dma_enable),
                .playback_fifo_empty        (playback_fifo_empty),
                .playback_fifo_data         (playback_fifo_data),
                .playback_fifo_read         (playback_fifo_read),
                .capture_dma_enable         (capture_dma_enable),
                .capture_fifo_full          (capture_fifo_full),
                .capture_fifo_write         (capture_fifo_write),
                .capture_fifo_data          (capture_fifo_data)
        );

        initial begin
                clock_bridge_0_out_clk_clk = 1'b0;
                forever #(clk_period / 2) clock_bridge_0_out_clk_clk = ~clock_bridge_0_out_clk_clk;
        end

        // whole run bounded at twice its nominal length
        initial begin
                #(watchdog_ns);
                $display("Timeout: run still going after %0d ns", watchdog_ns);
                $display("Done: errors found");
                $finish;
        end

        // ==================================================
        // models and helpers
        // ==================================================

        // taps 32 22 2 1
        function automatic logic [31:0] lfsr_step(input logic [31:0] s);
                return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
        endfunction

        task automatic random_frame(output i2s_pkg::frame_t f);
                f = '0;
                repeat (i2s_pkg::frame_w) begin
                        lfsr = lfsr_step(lfsr);             // one step per bit
                        f    = {f[i2s_pkg::frame_w-2:0], lfsr[0]};
                end
        endtask

        task automatic queue_frames(input int n);
                i2s_pkg::frame_t f;
                repeat (n) begin
                        random_frame(f);
                        play_q.push_back(f);
                end
        endtask

        task automatic check_value(input logic [63:0] got, input logic [63:0] expected,
                                   input string what);
                checks = checks + 1;
                if (got !== expected) begin
                        errors = errors + 1;
                        $display("Fail %0d ns: %s, got %h expected %h",
                                 $time, what, got, expected);
                end
        endtask

        // one system cycle ending on the falling clock edge
        task automatic step_cycle;
                @(negedge clock_bridge_0_out_clk_clk);
                if (pop_pending)
                        play_q.delete(0);               // consumed at the last rising edge
                pop_pending = playback_fifo_read;
                if (playback_fifo_read)
                        reads_seen = reads_seen + 1;
                if (capture_fifo_write) begin
                        writes_seen = writes_seen + 1;
                        cap_last    = capture_fifo_data;
                end
                if (quiet)
                        check_value(64'({playback_fifo_read, capture_fifo_write, aud_dacdat}),
                                    64'd0, "outputs active before first frame start");
                playback_fifo_empty = (play_q.size() == 0);
                playback_fifo_data  = (play_q.size() == 0) ? '1 : play_q[0];   // junk when empty
        endtask

        // codec moves word clock and adc data on its falling edge and samples dac on rising
        task automatic bit_slot(input logic adc_bit, input logic lr, output logic dac_bit);
                aud_bclk   = 1'b0;
                aud_lrclk  = lr;
                aud_adcdat = adc_bit;
                repeat (bclk_half) step_cycle();
                aud_bclk = 1'b1;
                dac_bit  = aud_dacdat;
                repeat (bclk_half) step_cycle();
        endtask

        // ==================================================
        // one frame period whose last slot is the next boundary
        // ==================================================

        task automatic run_frame;
                i2s_pkg::frame_t adc;
                i2s_pkg::frame_t next_play;
                logic [63:0]     adc_bits;
                logic [63:0]     dac_bits;
                logic            dac_bit;
                logic            will_read;
                logic            want_write;
                int              reads_before;
                int              writes_before;
                int              j;
                random_frame(adc);
                adc_bits      = {adc[31:0], adc[63:32]};  // left goes first
                dac_bits      = '0;
                will_read     = 1'b0;
                next_play     = '0;
                reads_before  = reads_seen;
                writes_before = writes_seen;
                for (j = 1; j <= 64; j = j + 1) begin
                        if (j == 64) begin                  // word clock drops and next frame loads
                                quiet     = 1'b0;
                                will_read = playback_dma_enable && (play_q.size() > 0);
                                next_play = will_read ? play_q[0] : '0;
                        end
                        bit_slot(adc_bits[63], (j >= 32) && (j < 64), dac_bit);  // high is right
                        adc_bits = adc_bits << 1;
                        dac_bits = {dac_bits[62:0], dac_bit};
                end
                check_value(dac_bits, {play_expect[31:0], play_expect[63:32]},
                            $sformatf("dac bits of frame %0d", frames_run));
                check_value(64'(reads_seen - reads_before), 64'(will_read),
                            $sformatf("playback reads in frame %0d", frames_run));
                // frame in flight at reset never reaches the fifo
                want_write = (frames_run > 0) && capture_dma_enable && !capture_fifo_full;
                check_value(64'(writes_seen - writes_before), 64'(want_write),
                            $sformatf("capture writes in frame %0d", frames_run));
                if (want_write)
                        check_value(cap_last, adc, $sformatf("captured frame %0d", frames_run));
                play_expect = next_play;
                frames_run  = frames_run + 1;
        endtask

        task automatic begin_test;
                test_errors = errors;
                test_frames = frames_run;
        endtask

        task automatic end_test(input string name);
                $display("test %s: %0d frames, %0d errors", name, frames_run - test_frames,
                         errors - test_errors);
        endtask

        // ==================================================
        // test sequence
        // ==================================================

        initial begin
                hps_0_h2f_reset_reset_n = 1'b0;
                aud_bclk                = 1'b1;
                aud_lrclk               = 1'b0;
                aud_adcdat              = 1'b0;
                playback_dma_enable     = 1'b1;
                playback_fifo_empty     = 1'b1;
                playback_fifo_data      = '1;
                capture_dma_enable      = 1'b1;
                capture_fifo_full       = 1'b0;
                lfsr        = seed;
                pop_pending = 1'b0;
                quiet       = 1'b1;
                play_expect = '0;                           // silence until first load
                cap_last    = '0;
                reads_seen  = 0;
                writes_seen = 0;
                errors      = 0;
                checks      = 0;
                frames_run  = 0;
                queue_frames(7);
                repeat (8) step_cycle();
                hps_0_h2f_reset_reset_n = 1'b1;

                begin_test();
                run_frame();
                end_test("reset");

                begin_test();
                repeat (6) run_frame();
                end_test("playback");

                begin_test();
                queue_frames(1);
                playback_dma_enable = 1'b0;                 // word waits in the fifo
                repeat (2) run_frame();
                playback_dma_enable = 1'b1;                 // one read and then underrun
                repeat (3) run_frame();
                end_test("playback gating");

                begin_test();
                queue_frames(6);
                repeat (6) run_frame();
                end_test("capture");

                begin_test();
                capture_fifo_full = 1'b1;
                repeat (2) run_frame();
                capture_fifo_full  = 1'b0;
                capture_dma_enable = 1'b0;
                repeat (2) run_frame();
                capture_dma_enable = 1'b1;
                repeat (2) run_frame();
                end_test("capture gating");

                errors = errors + uut.u_assert.fail_count;  // bound property failures
                $display("frames %0d, checks %0d, errors %0d", frames_run, checks, errors);
                if (errors == 0) begin
                        $display("Done: no errors");
                end else begin
                        $display("Done: errors found");
                end
                $finish;
        end

endmodule
